// File: project.f
design/cdac_pkg.sv
design/serial_clk_gen.sv
design/cdac_shift_fsm.sv
design/cdac_loader.sv
design/cdac_ctrl.sv
design/cdac_top.sv
tests/cdac_dac_model.sv
tests/tb_cdac_top.sv

// File: Bender.yml
package:
  name: cdac

sources:
  - files:
      - design/cdac_pkg.sv
      - design/serial_clk_gen.sv
      - design/cdac_shift_fsm.sv
      - design/cdac_loader.sv
      - design/cdac_ctrl.sv
      - design/cdac_top.sv
  - target: test
    files:
      - tests/cdac_dac_model.sv
      - tests/tb_cdac_top.sv

// File: tests/tb_cdac_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cdac_top import cdac_pkg::*; ();

	// Eight loads of under 900 cycles each, one idle window and register traffic
	localparam int unsigned TIMEOUT_CYCLES = 20000;
	localparam int unsigned DONE_LIMIT     = 1000;
	localparam int unsigned WORD_LIMIT     = 100;
	localparam int unsigned RANDOM_LOADS   = 6;

	logic        CLK40;
	logic        RST;
	logic        wr_stb;
	reg_addr_t   wr_addr;
	reg_data_t   wr_data;
	logic        rd_stb;
	reg_addr_t   rd_addr;
	reg_data_t   rd_data;
	logic        rd_valid;
	logic        sclk;
	logic        sclk_ena;
	logic        sdata;
	logic        dac_load;

	dac_word_t   rx_word;
	logic [7:0]  rx_bits;
	logic [15:0] rx_cnt;

	int unsigned cycle_cnt;
	int unsigned err_cnt;
	int unsigned test_cnt;
	int unsigned test_fail_cnt;
	int unsigned test_err_base;
	logic [31:0] rng_state;

	int unsigned sclk_half;
	logic        sclk_prev;
	logic        sclk_armed;

	cdac_top cdac_top_inst (
		.CLK40    (CLK40),
		.RST      (RST),
		.wr_stb   (wr_stb),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_stb   (rd_stb),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.sclk     (sclk),
		.sclk_ena (sclk_ena),
		.sdata    (sdata),
		.dac_load (dac_load)
	);

	cdac_dac_model dac_model_inst (
		.sclk      (sclk),
		.sclk_ena  (sclk_ena),
		.sdata     (sdata),
		.word      (rx_word),
		.word_bits (rx_bits),
		.word_cnt  (rx_cnt)
	);

	always #5 CLK40 = ~CLK40;

	always @(posedge CLK40) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Protocol properties
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge CLK40) disable iff (RST) rd_valid == $past(rd_stb))
	else begin
		$display("rd_valid did not follow rd_stb by exactly one cycle");
		err_cnt++;
	end

	// Shifted zeros fill in behind the word
	assert property (@(posedge CLK40) disable iff (RST) !sclk_ena |-> !sdata)
	else begin
		$display("sdata high outside the shift window");
		err_cnt++;
	end

	assert property (@(posedge CLK40) disable iff (RST) sclk_ena |-> dac_load)
	else begin
		$display("shift enable raised outside the load window");
		err_cnt++;
	end

	// sclk half period in CLK40 cycles, counted from the first toggle on
	always @(posedge CLK40) begin
		if (RST) begin
			sclk_prev  <= 1'b0;
			sclk_half  <= 0;
			sclk_armed <= 1'b0;
		end else if (sclk !== sclk_prev) begin
			assert (!sclk_armed || sclk_half == CLK_DIV_HALF) else begin
				$display("mismatch sclk half period: got %h expected %h",
					sclk_half, CLK_DIV_HALF);
				err_cnt++;
			end
			sclk_prev  <= sclk;
			sclk_half  <= 1;
			sclk_armed <= 1'b1;
		end else begin
			sclk_half <= sclk_half + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Three zeros, threshold, one trailing zero
	function automatic dac_word_t frame_word(input thresh_t t);
		return {3'b000, t, 1'b0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
		@(negedge CLK40);
		wr_stb  = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge CLK40);
		wr_stb  = 1'b0;
	endtask

	task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
		@(negedge CLK40);
		rd_stb  = 1'b1;
		rd_addr = addr;
		@(negedge CLK40);
		rd_stb  = 1'b0;
		assert (rd_valid === 1'b1) else begin
			$display("read of address %0d returned no valid strobe", addr);
			err_cnt++;
		end
		data = rd_data;
	endtask

	task automatic wait_done();
		reg_data_t   status;
		int unsigned waited;
		status = '0;
		waited = 0;
		while (status[0] !== 1'b1 && waited < DONE_LIMIT) begin
			reg_read(ADDR_STATUS, status);
			waited += 2;
		end
		assert (status[0] === 1'b1) else begin
			$display("done flag not seen within %0d cycles", DONE_LIMIT);
			err_cnt++;
		end
	endtask

	// Receiver hands over a word one sclk edge after the window closes
	task automatic wait_words(input logic [15:0] target);
		int unsigned waited;
		waited = 0;
		while (rx_cnt != target && waited < WORD_LIMIT) begin
			@(negedge CLK40);
			waited++;
		end
		check_value("rx_cnt", rx_cnt, target);
	endtask

	// Dropped request needs a few serial edges to rearm the FSM
	task automatic settle_serial();
		repeat (4) @(negedge sclk);
	endtask

	task automatic clear_done();
		reg_write(ADDR_CMD, 16'h0002);
	endtask

	task automatic load_and_check(input reg_data_t data);
		reg_data_t   status;
		logic [15:0] words_before;
		words_before = rx_cnt;
		reg_write(ADDR_THRESH, data);
		reg_write(ADDR_CMD, 16'h0001);
		reg_read(ADDR_STATUS, status);
		check_value("status busy and done", status[1:0], 2'b10);
		check_value("dac_load", dac_load, 1'b1);
		wait_done();
		check_value("dac_load", dac_load, 1'b0);
		wait_words(words_before + 16'd1);
		check_value("rx_word", rx_word, frame_word(data[11:0]));
		check_value("rx_bits", rx_bits, DAC_WORD_BITS);
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == test_err_base) begin
			$display("test %0d %s: pass", test_cnt, name);
		end else begin
			test_fail_cnt++;
			$display("test %0d %s: fail, %0d errors", test_cnt, name,
				err_cnt - test_err_base);
		end
		test_err_base = err_cnt;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reg_data_t   status;
		reg_data_t   rd_word;
		reg_data_t   last_data;
		logic [15:0] words_before;
		logic [7:0]  refused_before;

		CLK40         = 1'b0;
		RST           = 1'b1;
		wr_stb        = 1'b0;
		wr_addr       = '0;
		wr_data       = '0;
		rd_stb        = 1'b0;
		rd_addr       = '0;
		cycle_cnt     = 0;
		err_cnt       = 0;
		test_cnt      = 0;
		test_fail_cnt = 0;
		test_err_base = 0;
		rng_state     = 32'hd9b6;
		last_data     = '0;

		repeat (4) @(negedge CLK40);
		RST = 1'b0;

		check_value("dac_load", dac_load, 1'b0);
		check_value("sclk_ena", sclk_ena, 1'b0);
		check_value("sdata", sdata, 1'b0);
		check_value("sclk", sclk, 1'b0);
		reg_read(ADDR_STATUS, status);
		check_value("status", status, 16'h0000);
		end_test("reset state");

		load_and_check(16'h05a3);
		end_test("single load");

		clear_done();
		reg_read(ADDR_STATUS, status);
		check_value("status done", status[0], 1'b0);
		check_value("status busy", status[1], 1'b0);
		settle_serial();
		end_test("clear done");

		// Second command lands two cycles into the first load
		reg_read(ADDR_STATUS, status);
		refused_before = status[15:8];
		words_before   = rx_cnt;
		reg_write(ADDR_THRESH, 16'h0c3e);
		reg_write(ADDR_CMD, 16'h0001);
		reg_write(ADDR_CMD, 16'h0001);
		wait_done();
		wait_words(words_before + 16'd1);
		// A queued second load would need one more full load time to show up
		repeat (DONE_LIMIT) @(negedge CLK40);
		check_value("rx_cnt", rx_cnt, words_before + 16'd1);
		check_value("rx_word", rx_word, frame_word(12'hc3e));
		reg_read(ADDR_STATUS, status);
		check_value("refused count", status[15:8], refused_before + 8'd1);
		check_value("status busy", status[1], 1'b0);
		clear_done();
		end_test("load while busy");

		// Upper data bits are random too and only the low twelve are kept
		for (int i = 0; i < RANDOM_LOADS; i++) begin
			rng_state = xorshift32(rng_state);
			last_data = rng_state[15:0];
			load_and_check(last_data);
			clear_done();
			settle_serial();
		end
		reg_read(ADDR_THRESH, rd_word);
		check_value("threshold readback", rd_word, {4'b0000, last_data[11:0]});
		end_test("random loads");

		$display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/cdac_dac_model.sv
`timescale 1ns/1ns
`default_nettype none

module cdac_dac_model import cdac_pkg::*; (
	input  wire         sclk,
	input  wire         sclk_ena,
	input  wire         sdata,
	output dac_word_t   word,
	output logic [7:0]  word_bits,
	output logic [15:0] word_cnt
);

	dac_word_t   rx_shift = '0;
	logic [7:0]  rx_bits  = 8'd0;
	dac_word_t   last_word = '0;
	logic [7:0]  last_bits = 8'd0;
	logic [15:0] rx_words  = 16'd0;

	// Bits arrive MSB first, one per rising edge inside the enable window.
	// The first rising edge after the window closes hands the word over.
	always @(posedge sclk) begin
		if (sclk_ena === 1'b1) begin
			rx_shift <= {rx_shift[DAC_WORD_BITS-2:0], sdata};
			rx_bits  <= rx_bits + 8'd1;
		end else if (rx_bits != 8'd0) begin
			last_word <= rx_shift;
			last_bits <= rx_bits;
			rx_words  <= rx_words + 16'd1;
			rx_bits   <= 8'd0;
		end
	end

	assign word      = last_word;
	assign word_bits = last_bits;
	assign word_cnt  = rx_words;

endmodule

`default_nettype wire

// File: design/cdac_top.sv
`timescale 1ns/1ns
`default_nettype none

module cdac_top import cdac_pkg::*; (
	input  wire            CLK40,
	input  wire            RST,
	input  wire            wr_stb,
	input  wire reg_addr_t wr_addr,
	input  wire reg_data_t wr_data,
	input  wire            rd_stb,
	input  wire reg_addr_t rd_addr,
	output wire reg_data_t rd_data,
	output wire            rd_valid,
	output wire            sclk,
	output wire            sclk_ena,
	output wire            sdata,
	output wire            dac_load
);

	wire     busy;
	wire     done;
	wire     capture;
	wire     clr_done;
	thresh_t thresh;

	// 1 MHz serial clock
	serial_clk_gen serial_clk_gen_inst (
		.CLK40 (CLK40),
		.RST   (RST),
		.sclk  (sclk)
	);

	// Host register port
	cdac_ctrl cdac_ctrl_inst (
		.CLK40    (CLK40),
		.RST      (RST),
		.wr_stb   (wr_stb),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_stb   (rd_stb),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.busy     (busy),
		.done     (done),
		.capture  (capture),
		.clr_done (clr_done),
		.thresh   (thresh)
	);

	cdac_loader cdac_loader_inst (
		.CLK40    (CLK40),
		.sclk     (sclk),
		.RST      (RST),
		.capture  (capture),
		.thresh   (thresh),
		.clr_done (clr_done),
		.dac_load (dac_load),
		.sclk_ena (sclk_ena),
		.sdata    (sdata),
		.busy     (busy),
		.done     (done)
	);

endmodule

`default_nettype wire

// File: design/cdac_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cdac_ctrl import cdac_pkg::*; (
	input  wire            CLK40,
	input  wire            RST,
	input  wire            wr_stb,
	input  wire reg_addr_t wr_addr,
	input  wire reg_data_t wr_data,
	input  wire            rd_stb,
	input  wire reg_addr_t rd_addr,
	output reg_data_t      rd_data,
	output logic           rd_valid,
	input  wire            busy,
	input  wire            done,
	output logic           capture,
	output logic           clr_done,
	output thresh_t        thresh
);

	logic       cmd_wr;
	logic       load_hit;
	logic [7:0] refused_cnt;

	// Command decode, bit 0 loads and bit 1 clears done
	assign cmd_wr   = wr_stb && (wr_addr == ADDR_CMD);
	assign load_hit = cmd_wr && wr_data[0];
	assign capture  = load_hit && !busy;
	assign clr_done = cmd_wr && wr_data[1];

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			thresh <= '0;
		end else if (wr_stb && (wr_addr == ADDR_THRESH)) begin
			thresh <= wr_data[$bits(thresh_t)-1:0];
		end
	end

	// Loads refused while busy, saturates at 255
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			refused_cnt <= 8'd0;
		end else if (load_hit && busy && (refused_cnt != 8'hff)) begin
			refused_cnt <= refused_cnt + 8'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port, one cycle latency
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_stb;
		end
	end

	always_ff @(posedge CLK40) begin
		if (rd_stb) begin
			case (rd_addr)
				ADDR_THRESH: rd_data <= {4'b0000, thresh};
				ADDR_STATUS: rd_data <= {refused_cnt, 6'b000000, busy, done};
				default:     rd_data <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/cdac_loader.sv
`timescale 1ns/1ns
`default_nettype none

module cdac_loader import cdac_pkg::*; (
	input  wire          CLK40,
	input  wire          sclk,
	input  wire          RST,
	input  wire          capture,
	input  wire thresh_t thresh,
	input  wire          clr_done,
	output logic         dac_load,
	output logic         sclk_ena,
	output logic         sdata,
	output logic         busy,
	output logic         done
);

	thresh_t    thresh_hold;
	logic       load_req;

	logic       req_s1;
	logic       req_s2;
	logic       req_s3;
	logic       load_edge;

	dac_word_t  shift_reg;
	shift_cnt_t cnt;
	logic       clr_cnt;
	logic       shift_ena;
	logic       set_done;

	logic       done_s1;
	logic       done_s2;
	logic       done_s3;
	logic       done_rise;

	////////////////////////////////////////////////////////////////////////////
	// CLK40 side
	////////////////////////////////////////////////////////////////////////////

	// Threshold stays put until the next capture
	always_ff @(posedge CLK40) begin
		if (capture) begin
			thresh_hold <= thresh;
		end
	end

	// Request stays up for the whole load, dropped once done arrives
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			load_req <= 1'b0;
		end else if (done_rise) begin
			load_req <= 1'b0;
		end else if (capture) begin
			load_req <= 1'b1;
		end
	end

	assign dac_load = load_req;
	assign busy     = load_req;

	// set_done back into CLK40, then edge detect
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			done_s1 <= 1'b0;
			done_s2 <= 1'b0;
			done_s3 <= 1'b0;
		end else begin
			done_s1 <= set_done;
			done_s2 <= done_s1;
			done_s3 <= done_s2;
		end
	end

	assign done_rise = done_s2 & ~done_s3;

	// A new completion wins over a clear in the same cycle
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			done <= 1'b0;
		end else if (done_rise) begin
			done <= 1'b1;
		end else if (clr_done) begin
			done <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Serial clock side, all on falling edges
	////////////////////////////////////////////////////////////////////////////

	always_ff @(negedge sclk or posedge RST) begin
		if (RST) begin
			req_s1 <= 1'b0;
			req_s2 <= 1'b0;
			req_s3 <= 1'b0;
		end else begin
			req_s1 <= load_req;
			req_s2 <= req_s1;
			req_s3 <= req_s2;
		end
	end

	// First falling edge that sees the synchronized request
	assign load_edge = req_s2 & ~req_s3;

	// Framed word in, then MSB first with zeros filling behind
	always_ff @(negedge sclk or posedge RST) begin
		if (RST) begin
			shift_reg <= '0;
		end else if (load_edge) begin
			shift_reg <= {3'b000, thresh_hold, 1'b0};
		end else if (shift_ena) begin
			shift_reg <= {shift_reg[DAC_WORD_BITS-2:0], 1'b0};
		end
	end

	always_ff @(negedge sclk or posedge RST) begin
		if (RST) begin
			cnt <= '0;
		end else if (clr_cnt) begin
			cnt <= '0;
		end else if (shift_ena) begin
			cnt <= cnt + shift_cnt_t'(1);
		end
	end

	cdac_shift_fsm cdac_shift_fsm_inst (
		.sclk      (sclk),
		.RST       (RST),
		.start     (req_s2),
		.cnt       (cnt),
		.clr_cnt   (clr_cnt),
		.shift_ena (shift_ena),
		.set_done  (set_done)
	);

	assign sclk_ena = shift_ena;
	assign sdata    = shift_reg[DAC_WORD_BITS-1];

endmodule

`default_nettype wire

// File: design/cdac_shift_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module cdac_shift_fsm import cdac_pkg::*; (
	input  wire        sclk,
	input  wire        RST,
	input  wire        start,
	input  wire shift_cnt_t cnt,
	output logic       clr_cnt,
	output logic       shift_ena,
	output logic       set_done
);

	shift_state_t state;
	shift_state_t state_nxt;
	logic         last_bit;

	// Counter value of the final bit of the word
	assign last_bit = (cnt == shift_cnt_t'(DAC_WORD_BITS - 1));

	////////////////////////////////////////////////////////////////////////////
	// State register, falling edge of the serial clock
	////////////////////////////////////////////////////////////////////////////

	always_ff @(negedge sclk or posedge RST) begin
		if (RST) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start) begin
					state_nxt = ST_SHIFT;
				end
			end
			ST_SHIFT: begin
				// Leave after the 16th bit has been presented
				if (last_bit) begin
					state_nxt = ST_HOLD;
				end
			end
			ST_HOLD: begin
				// Wait for the request to drop before rearming
				if (!start) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs decoded from state
	////////////////////////////////////////////////////////////////////////////

	// Counter held at zero while idle
	assign clr_cnt = (state == ST_IDLE);

	assign shift_ena = (state == ST_SHIFT);

	// Held until the CLK40 side drops the request
	assign set_done = (state == ST_HOLD);

endmodule

`default_nettype wire

// File: design/serial_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module serial_clk_gen import cdac_pkg::*; (
	input  wire  CLK40,
	input  wire  RST,
	output logic sclk
);

	localparam int unsigned DIV_W = $clog2(CLK_DIV_HALF);

	logic [DIV_W-1:0] div_cnt;
	logic             half_end;

	// Last CLK40 cycle of a half period
	assign half_end = (div_cnt == DIV_W'(CLK_DIV_HALF - 1));

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			div_cnt <= '0;
		end else if (half_end) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	// Toggle once per half period, 40 CLK40 cycles per sclk period
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			sclk <= 1'b0;
		end else if (half_end) begin
			sclk <= ~sclk;
		end
	end

endmodule

`default_nettype wire

// File: design/cdac_pkg.sv
`default_nettype none

package cdac_pkg;

	// One DAC word, three leading zeros, threshold, one trailing zero
	localparam int unsigned DAC_WORD_BITS = 16;

	// CLK40 cycles per half period of the 1 MHz serial clock
	localparam int unsigned CLK_DIV_HALF = 20;

	typedef logic [11:0] thresh_t;
	typedef logic [DAC_WORD_BITS-1:0] dac_word_t;
	typedef logic [3:0] shift_cnt_t;
	typedef logic [1:0] reg_addr_t;
	typedef logic [15:0] reg_data_t;

	// Shift sequencer states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_HOLD
	} shift_state_t;

	// Register map
	localparam reg_addr_t ADDR_THRESH = 2'd0;
	localparam reg_addr_t ADDR_CMD    = 2'd1;
	localparam reg_addr_t ADDR_STATUS = 2'd2;

endpackage

`default_nettype wire
